// ==== rmii_pkg.sv ====
package rmii_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////
    localparam int QUEUE_DEPTH      = 2048;
    localparam int QUEUE_ADDR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int MIN_FRAME_BYTES  = 64;

    typedef logic [1:0]                      dibit_t;
    typedef logic [7:0]                      byte_t;
    typedef logic [8:0]                      word_t;
    typedef logic [31:0]                     crc_t;
    typedef logic [QUEUE_ADDR_WIDTH-1:0]     queue_addr_t;
    typedef logic [$clog2(MIN_FRAME_BYTES):0] frame_count_t;

    // Line codes, first dibit on the wire in bits 1:0
    localparam dibit_t PREAMBLE_DIBIT = 2'b01;
    localparam dibit_t SFD_DIBIT      = 2'b11;

    //////////////////////////////
    // CRC-32
    //////////////////////////////
    localparam crc_t CRC_POLY    = 32'hEDB88320;
    localparam crc_t CRC_INIT    = 32'hFFFFFFFF;
    // Good-frame residue, MSB-first form
    localparam crc_t FCS_RESIDUE = 32'hC704DD7B;

    typedef enum logic [1:0] {
        HUNT,
        PREAMBLE,
        DATA
    } packager_state_t;

    // One byte, LSB first, reflected register
    function automatic crc_t crc_next_byte(input crc_t crc, input byte_t data);
        crc_t next;
        next = crc;
        for (int i = 0; i < 8; i++) begin
            if (next[0] ^ data[i]) begin
                next = (next >> 1) ^ CRC_POLY;
            end else begin
                next = next >> 1;
            end
        end
        return next;
    endfunction

endpackage

// ==== byte_stream_if.sv ====
`timescale 1ns/1ps

interface byte_stream_if;

    rmii_pkg::byte_t data;
    logic            valid;
    // Only meaningful while valid is high
    logic            last;
    logic            error;

    modport source (
        output data,
        output valid,
        output last,
        output error
    );

    modport sink (
        input data,
        input valid,
        input last,
        input error
    );

endinterface

// ==== rmii_byte_packager.sv ====
`timescale 1ns/1ps

module rmii_byte_packager (
    input  logic              clock,
    input  logic              reset,
    input  rmii_pkg::dibit_t  rmii_receive_data,
    input  logic              rmii_receive_data_enable,
    input  logic              rmii_receive_data_error,
    byte_stream_if.source     out
);

    rmii_pkg::packager_state_t state;
    rmii_pkg::byte_t           shift_register;
    rmii_pkg::byte_t           assembled_byte;
    rmii_pkg::byte_t           hold_byte;
    logic [1:0]                dibit_count;
    logic                      hold_valid;
    logic                      frame_error;
    logic                      flush;

    // New dibit lands on top, earlier ones move down
    assign assembled_byte = {rmii_receive_data, shift_register[7:2]};

    //////////////////////////////
    // Control
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= rmii_pkg::HUNT;
            dibit_count <= 2'd0;
            hold_valid  <= 1'b0;
            frame_error <= 1'b0;
            flush       <= 1'b0;
            out.valid   <= 1'b0;
            out.last    <= 1'b0;
            out.error   <= 1'b0;
        end else begin
            out.valid <= 1'b0;
            out.last  <= 1'b0;
            out.error <= 1'b0;
            flush     <= 1'b0;

            // Held byte closes the frame
            if (flush) begin
                out.valid  <= 1'b1;
                out.last   <= 1'b1;
                out.error  <= frame_error;
                hold_valid <= 1'b0;
            end

            case (state)
                rmii_pkg::HUNT: begin
                    if (rmii_receive_data_enable &&
                        rmii_receive_data == rmii_pkg::PREAMBLE_DIBIT) begin
                        state <= rmii_pkg::PREAMBLE;
                    end
                end

                rmii_pkg::PREAMBLE: begin
                    if (!rmii_receive_data_enable) begin
                        state <= rmii_pkg::HUNT;
                    end else if (rmii_receive_data == rmii_pkg::SFD_DIBIT) begin
                        state       <= rmii_pkg::DATA;
                        dibit_count <= 2'd0;
                        frame_error <= 1'b0;
                    end else if (rmii_receive_data != rmii_pkg::PREAMBLE_DIBIT) begin
                        state <= rmii_pkg::HUNT;
                    end
                end

                rmii_pkg::DATA: begin
                    if (rmii_receive_data_enable) begin
                        dibit_count <= dibit_count + 2'd1;
                        if (rmii_receive_data_error) begin
                            frame_error <= 1'b1;
                        end
                        if (dibit_count == 2'd3) begin
                            hold_valid <= 1'b1;
                            out.valid  <= hold_valid;
                        end
                    end else begin
                        state <= rmii_pkg::HUNT;
                        // Partial trailing byte spoils the frame
                        if (hold_valid) begin
                            flush       <= 1'b1;
                            frame_error <= frame_error | (dibit_count != 2'd0);
                        end
                    end
                end

                default: state <= rmii_pkg::HUNT;
            endcase
        end
    end

    //////////////////////////////
    // Byte assembly
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (state == rmii_pkg::DATA && rmii_receive_data_enable) begin
            shift_register <= assembled_byte;
            if (dibit_count == 2'd3) begin
                hold_byte <= assembled_byte;
                out.data  <= hold_byte;
            end
        end else if (flush) begin
            out.data <= hold_byte;
        end
    end

    // Bytes are four clocks apart and the flush waits one extra clock
    assert property (@(posedge clock) disable iff (reset)
        out.valid |=> !out.valid);

endmodule

// ==== frame_checker.sv ====
`timescale 1ns/1ps

module frame_checker (
    input  logic          clock,
    input  logic          reset,
    byte_stream_if.sink   in,
    byte_stream_if.source out
);

    rmii_pkg::crc_t         crc;
    rmii_pkg::crc_t         crc_updated;
    rmii_pkg::crc_t         crc_mirror;
    rmii_pkg::frame_count_t byte_count;
    rmii_pkg::frame_count_t byte_count_next;
    logic                   crc_bad;
    logic                   too_short;

    assign crc_updated = rmii_pkg::crc_next_byte(crc, in.data);

    // Register runs reflected, residue is kept MSB first
    assign crc_mirror = {<<{crc_updated}};
    assign crc_bad    = (crc_mirror != rmii_pkg::FCS_RESIDUE);

    // Count includes the current byte
    assign byte_count_next = (byte_count == rmii_pkg::frame_count_t'(rmii_pkg::MIN_FRAME_BYTES))
                           ? byte_count
                           : byte_count + 1'b1;
    assign too_short = (byte_count_next < rmii_pkg::frame_count_t'(rmii_pkg::MIN_FRAME_BYTES));

    //////////////////////////////
    // Running state
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            crc        <= rmii_pkg::CRC_INIT;
            byte_count <= '0;
            out.valid  <= 1'b0;
        end else begin
            out.valid <= in.valid;
            if (in.valid) begin
                if (in.last) begin
                    crc        <= rmii_pkg::CRC_INIT;
                    byte_count <= '0;
                end else begin
                    crc        <= crc_updated;
                    byte_count <= byte_count_next;
                end
            end
        end
    end

    // Beat payload
    always_ff @(posedge clock) begin
        out.data  <= in.data;
        out.last  <= in.last;
        out.error <= in.last & (in.error | crc_bad | too_short);
    end

    // Frame markers only ride on a valid beat
    assert property (@(posedge clock) disable iff (reset)
        (in.last || in.error) |-> in.valid);

endmodule

// ==== frame_queue.sv ====
`timescale 1ns/1ps

module frame_queue (
    input  logic           clock,
    input  logic           reset,
    byte_stream_if.sink    in,
    output rmii_pkg::word_t receive_data,
    output logic           receive_data_valid,
    input  logic           receive_data_enable
);

    rmii_pkg::word_t       memory [rmii_pkg::QUEUE_DEPTH];
    rmii_pkg::queue_addr_t write_pointer;
    rmii_pkg::queue_addr_t commit_pointer;
    rmii_pkg::queue_addr_t read_pointer;
    logic                  dropping;
    logic                  space;
    logic                  accept;
    logic                  overflow;
    logic                  fetch;

    //////////////////////////////
    // Write side
    //////////////////////////////

    // One slot stays free to tell full from empty
    assign space    = (rmii_pkg::queue_addr_t'(write_pointer + 1'b1) != read_pointer);
    assign accept   = in.valid && !dropping && space;
    assign overflow = in.valid && !dropping && !space;

    always_ff @(posedge clock) begin
        if (accept) begin
            memory[write_pointer] <= {in.last, in.data};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            write_pointer  <= '0;
            commit_pointer <= '0;
            dropping       <= 1'b0;
        end else if (accept) begin
            if (in.last && in.error) begin
                write_pointer <= commit_pointer;
            end else begin
                write_pointer <= write_pointer + 1'b1;
                if (in.last) begin
                    commit_pointer <= write_pointer + 1'b1;
                end
            end
        end else if (overflow) begin
            // Discard the partial frame, skip the rest of it
            write_pointer <= commit_pointer;
            dropping      <= !in.last;
        end else if (in.valid && in.last) begin
            dropping <= 1'b0;
        end
    end

    //////////////////////////////
    // Read side
    //////////////////////////////

    // Output register refills when empty or being taken
    assign fetch = (read_pointer != commit_pointer) &&
                   (!receive_data_valid || receive_data_enable);

    always_ff @(posedge clock) begin
        if (fetch) begin
            receive_data <= memory[read_pointer];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            read_pointer       <= '0;
            receive_data_valid <= 1'b0;
        end else if (fetch) begin
            read_pointer       <= read_pointer + 1'b1;
            receive_data_valid <= 1'b1;
        end else if (receive_data_enable) begin
            receive_data_valid <= 1'b0;
        end
    end

    // Committed words always sit inside the written region
    assert property (@(posedge clock) disable iff (reset)
        rmii_pkg::queue_addr_t'(write_pointer - read_pointer) >=
        rmii_pkg::queue_addr_t'(commit_pointer - read_pointer));

endmodule

// ==== rmii_port.sv ====
`timescale 1ns/1ps

module rmii_port (
    input  logic              clock,
    input  logic              reset,
    input  rmii_pkg::dibit_t  rmii_receive_data,
    input  logic              rmii_receive_data_enable,
    input  logic              rmii_receive_data_error,
    input  logic              receive_data_enable,

    output rmii_pkg::word_t   receive_data,
    output logic              receive_data_valid
);

    byte_stream_if pack_to_check ();
    byte_stream_if check_to_queue ();

    //////////////////////////////
    // PHY dibits to bytes
    //////////////////////////////
    rmii_byte_packager rmii_byte_packager (
        .clock                    (clock),
        .reset                    (reset),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .out                      (pack_to_check)
    );

    // FCS and length check
    frame_checker frame_checker (
        .clock (clock),
        .reset (reset),
        .in    (pack_to_check),
        .out   (check_to_queue)
    );

    //////////////////////////////
    // Store and forward to core
    //////////////////////////////
    frame_queue frame_queue (
        .clock               (clock),
        .reset               (reset),
        .in                  (check_to_queue),
        .receive_data        (receive_data),
        .receive_data_valid  (receive_data_valid),
        .receive_data_enable (receive_data_enable)
    );

endmodule

// ==== rmii_frame_tasks.svh ====
`ifndef RMII_FRAME_TASKS_SVH
`define RMII_FRAME_TASKS_SVH

//////////////////////////////
// Frame building
//////////////////////////////
rmii_pkg::byte_t frame_bytes[$];
logic [31:0]     payload_state = LCG_SEED;

// Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Random payload then FCS, total length includes the FCS
task automatic build_frame(input int total_bytes);
    rmii_pkg::crc_t  crc;
    rmii_pkg::byte_t data;
    frame_bytes.delete();
    crc = rmii_pkg::CRC_INIT;
    for (int i = 0; i < total_bytes - 4; i++) begin
        payload_state = lcg_next(payload_state);
        data = payload_state[23:16];
        frame_bytes.push_back(data);
        crc = rmii_pkg::crc_next_byte(crc, data);
    end
    // FCS goes out complemented, low byte first
    crc = ~crc;
    for (int i = 0; i < 4; i++) begin
        frame_bytes.push_back(crc[8*i +: 8]);
    end
endtask

// Words the core should see, end marker on the final byte
task automatic expect_frame();
    rmii_pkg::word_t word;
    foreach (frame_bytes[i]) begin
        word = {1'b0, frame_bytes[i]};
        word[8] = (i == frame_bytes.size() - 1);
        expected_words.push_back(word);
    end
endtask

//////////////////////////////
// RMII driver
//////////////////////////////
task automatic drive_dibit(input rmii_pkg::dibit_t dibit, input logic enable,
                           input logic error);
    @(posedge clock);
    rmii_receive_data        <= dibit;
    rmii_receive_data_enable <= enable;
    rmii_receive_data_error  <= error;
endtask

// dibit_limit of zero sends the whole frame, error_dibit below zero sends no error
task automatic send_frame(input int dibit_limit, input int error_dibit);
    rmii_pkg::byte_t data;
    int              total;
    total = frame_bytes.size() * 4;
    if (dibit_limit > 0 && dibit_limit < total) begin
        total = dibit_limit;
    end
    // Seven preamble bytes then the delimiter
    for (int i = 0; i < 8; i++) begin
        data = (i == 7) ? 8'hD5 : 8'h55;
        for (int j = 0; j < 4; j++) begin
            drive_dibit(data[2*j +: 2], 1'b1, 1'b0);
        end
    end
    for (int k = 0; k < total; k++) begin
        data = frame_bytes[k / 4];
        drive_dibit(data[2*(k % 4) +: 2], 1'b1, k == error_dibit);
    end
    // Inter-frame gap
    repeat (12) drive_dibit(2'b00, 1'b0, 1'b0);
endtask

`endif

// ==== rmii_port_tb.sv ====
`timescale 1ns/1ps

module rmii_port_tb;

    localparam logic [31:0] LCG_SEED          = 32'h1376f064;
    localparam int          DRAIN_LIMIT       = 4000;
    // Sum of the frame lengths sent below, random ones at their maximum
    localparam int          TOTAL_FRAME_BYTES = 100 + 200 + 301 + 124 + 10 * 320 + 2500;
    localparam longint      WATCHDOG_NS       = longint'(TOTAL_FRAME_BYTES) * 4 * 10 * 3 + 10_000;

    logic             clock;
    logic             reset;
    rmii_pkg::dibit_t rmii_receive_data;
    logic             rmii_receive_data_enable;
    logic             rmii_receive_data_error;
    logic             receive_data_enable;
    rmii_pkg::word_t  receive_data;
    logic             receive_data_valid;

    rmii_pkg::word_t  expected_words[$];
    rmii_pkg::word_t  expected_head = '0;
    int               expected_count = 0;
    logic [1:0]       enable_mode = 2'd1;
    logic [31:0]      enable_state;
    int               error_count = 0;
    int               tests_passed = 0;
    int               tests_failed = 0;

    `include "rmii_frame_tasks.svh"

    rmii_port UUT (
        .clock                    (clock),
        .reset                    (reset),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .receive_data_enable      (receive_data_enable),
        .receive_data             (receive_data),
        .receive_data_valid       (receive_data_valid)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Core side enable, mode 0 low, 1 high, 2 random
    initial begin
        enable_state        = LCG_SEED;
        receive_data_enable = 1'b0;
        forever begin
            @(posedge clock);
            enable_state = lcg_next(enable_state);
            case (enable_mode)
                2'd0:    receive_data_enable <= 1'b0;
                2'd1:    receive_data_enable <= 1'b1;
                default: receive_data_enable <= enable_state[28];
            endcase
        end
    end

    //////////////////////////////
    // Scoreboard
    //////////////////////////////
    always @(posedge clock) begin
        if (!reset && receive_data_valid && receive_data_enable && expected_words.size() != 0) begin
            void'(expected_words.pop_front());
        end
    end

    // Stable copy of the queue head for the assertions
    always @(negedge clock) begin
        expected_count <= expected_words.size();
        expected_head  <= (expected_words.size() != 0) ? expected_words[0] : '0;
    end

    assert property (@(posedge clock) disable iff (reset)
        (receive_data_valid && receive_data_enable) |-> (expected_count != 0))
    else begin
        $display("Word %h accepted while no frame was expected", $sampled(receive_data));
        error_count++;
    end

    assert property (@(posedge clock) disable iff (reset)
        (receive_data_valid && receive_data_enable && expected_count != 0) |->
        (receive_data == expected_head))
    else begin
        $display("[FAIL] receive_data expected %h actual %h",
                 $sampled(expected_head), $sampled(receive_data));
        error_count++;
    end

    // Held word under back-pressure
    assert property (@(posedge clock) disable iff (reset)
        (receive_data_valid && !receive_data_enable) |=>
        (receive_data_valid && $stable(receive_data)))
    else begin
        $display("Output word changed or vanished while the core held it back");
        error_count++;
    end

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((expected_words.size() != 0 || receive_data_valid) && cycles < DRAIN_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        // Room for a wrongly delivered frame to show up
        repeat (20) @(posedge clock);
        if (expected_words.size() != 0) begin
            $display("Frame missing, %0d expected words never arrived", expected_words.size());
            error_count++;
            expected_words.delete();
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////
    initial begin
        int errors_before;
        int length;
        reset                    = 1'b1;
        rmii_receive_data        = 2'b00;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        errors_before = error_count;
        build_frame(100);
        expect_frame();
        send_frame(0, -1);
        wait_drained();
        report_test("good 100-byte frame", errors_before);

        errors_before = error_count;
        build_frame(100);
        frame_bytes[98] = frame_bytes[98] ^ 8'h10;
        send_frame(0, -1);
        build_frame(100);
        expect_frame();
        send_frame(0, -1);
        wait_drained();
        report_test("corrupted FCS dropped", errors_before);

        errors_before = error_count;
        build_frame(100);
        send_frame(0, 180);
        build_frame(100);
        // Good frame then two dibits of a stray byte
        frame_bytes.push_back(8'h00);
        send_frame(100 * 4 + 2, -1);
        build_frame(100);
        expect_frame();
        send_frame(0, -1);
        wait_drained();
        report_test("receive error and cut frame dropped", errors_before);

        errors_before = error_count;
        build_frame(60);
        send_frame(0, -1);
        build_frame(64);
        expect_frame();
        send_frame(0, -1);
        wait_drained();
        report_test("minimum frame length", errors_before);

        errors_before = error_count;
        enable_mode <= 2'd2;
        for (int n = 0; n < 10; n++) begin
            payload_state = lcg_next(payload_state);
            length = 64 + int'(payload_state[31:24]);
            build_frame(length);
            expect_frame();
            send_frame(0, -1);
        end
        wait_drained();
        enable_mode <= 2'd1;
        report_test("random back-pressure", errors_before);

        errors_before = error_count;
        enable_mode <= 2'd0;
        build_frame(1500);
        expect_frame();
        send_frame(0, -1);
        build_frame(1000);
        send_frame(0, -1);
        enable_mode <= 2'd1;
        wait_drained();
        report_test("queue overflow", errors_before);

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
rmii_pkg.sv
byte_stream_if.sv
rmii_byte_packager.sv
frame_checker.sv
frame_queue.sv
rmii_port.sv
rmii_port_tb.sv
